/* Bender.yml */
package:
  name: s46_peripherals

sources:
  - verilog/s46_pkg.sv
  - verilog/nibble_ram.sv
  - verilog/clock_timer.sv
  - verilog/prog_timer.sv
  - verilog/input_port.sv
  - verilog/interrupt_ctrl.sv
  - verilog/mem_map.sv
  - verilog/s46_peripherals.sv
  - target: test
    files:
      - tests/tb_s46_peripherals.sv

/* s46_peripherals.f */
verilog/s46_pkg.sv
verilog/nibble_ram.sv
verilog/clock_timer.sv
verilog/prog_timer.sv
verilog/input_port.sv
verilog/interrupt_ctrl.sv
verilog/mem_map.sv
verilog/s46_peripherals.sv
tests/tb_s46_peripherals.sv

/* tests/tb_s46_peripherals.sv */
`timescale 1ns/1ps

module tb_s46_peripherals;
  import s46_pkg::*;

  localparam int CLK_PERIOD = 4;

  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ = 3'd1;
  localparam logic [2:0] OP_INPUT = 3'd2;
  localparam logic [2:0] OP_IDLE = 3'd3;
  localparam logic [2:0] OP_VIDEO = 3'd4;
  localparam logic [2:0] OP_IRQ = 3'd5;

  // One row of the stimulus table
  typedef struct packed {
    logic [2:0]        op;
    logic [ADDR_W-1:0] addr;
    logic [NIB_W-1:0]  data;
    logic [NIB_W-1:0]  expected;
    logic [15:0]       wait_cycles;
  } step_t;

  logic             clk;
  logic             reset_n;
  logic             clk_en;
  mem_req_t         mem_req;
  logic [NIB_W-1:0] read_data;
  logic [3:0]       input_k0;
  logic [3:0]       input_k1;
  logic [7:0]       video_addr;
  logic [NIB_W-1:0] video_data;
  irq_t             interrupt_req;

  step_t            steps[$];
  logic [NIB_W-1:0] model_mem [4096];
  logic [7:0]       since_clear;
  integer           seed;
  bit               table_ready;

  s46_peripherals UUT (
    .clk           (clk),
    .reset_n       (reset_n),
    .clk_en        (clk_en),
    .mem_req       (mem_req),
    .read_data     (read_data),
    .input_k0      (input_k0),
    .input_k1      (input_k1),
    .video_addr    (video_addr),
    .video_data    (video_data),
    .interrupt_req (interrupt_req)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [NIB_W-1:0] rand_nibble();
    return 4'($random(seed));
  endfunction

  function automatic logic [ADDR_W-1:0] io(input logic [7:0] offset);
    return {IO_PAGE, offset};
  endfunction

  // Maps a display index back to its bus address
  // Indices above the top fold to index 0
  function automatic logic [ADDR_W-1:0] index_to_bus(input logic [7:0] idx);
    if (idx < VRAM_WIN) begin
      return VRAM_LO_BASE + idx;
    end else if (idx < VRAM_DEPTH) begin
      return VRAM_HI_BASE + idx - VRAM_WIN;
    end
    return VRAM_LO_BASE;
  endfunction

  task automatic add_step(input logic [2:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [NIB_W-1:0] data, input logic [NIB_W-1:0] expected,
                          input int wait_cycles);
    step_t s;
    s.op = op;
    s.addr = addr;
    s.data = data;
    s.expected = expected;
    s.wait_cycles = 16'(wait_cycles);
    steps.push_back(s);
    // Tap counter advances once per clock
    if (op == OP_IDLE) begin
      since_clear += 8'(wait_cycles);
    end else if (op != OP_IRQ) begin
      since_clear += 8'd1;
    end
  endtask

  task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [NIB_W-1:0] data);
    model_mem[addr] = data;
    add_step(OP_WRITE, addr, data, '0, 0);
  endtask

  task automatic add_read(input logic [ADDR_W-1:0] addr, input logic [NIB_W-1:0] expected);
    add_step(OP_READ, addr, '0, expected, 0);
  endtask

  task automatic build_table();
    logic [ADDR_W-1:0] ram_addrs [5];
    irq_t              irq_sel;
    ram_addrs = '{12'h000, 12'h07F, 12'h123, 12'h1A5, 12'h27F};
    foreach (ram_addrs[i]) add_write(ram_addrs[i], rand_nibble());
    foreach (ram_addrs[i]) add_read(ram_addrs[i], model_mem[ram_addrs[i]]);
    // Display windows and the video port
    add_write(12'hE85, rand_nibble());
    add_write(12'hE10, rand_nibble());
    add_read(12'hE85, model_mem[12'hE85]);
    add_read(12'hE10, model_mem[12'hE10]);
    add_step(OP_VIDEO, 12'h055, '0, model_mem[index_to_bus(8'h55)], 0);
    add_step(OP_VIDEO, 12'h010, '0, model_mem[index_to_bus(8'h10)], 0);
    // Unmapped space
    add_read(12'h500, 4'h0);
    add_read(12'hE50, 4'h0);
    add_read(io(8'h33), 4'h0);
    add_write(io(IO_CLK_MASK), rand_nibble());
    add_write(io(IO_PT_RELOAD_LO), rand_nibble());
    add_write(io(IO_PT_RELOAD_HI), rand_nibble());
    add_write(io(IO_PT_MASK), rand_nibble());
    add_read(io(IO_CLK_MASK), model_mem[io(IO_CLK_MASK)]);
    add_read(io(IO_PT_RELOAD_LO), model_mem[io(IO_PT_RELOAD_LO)]);
    add_read(io(IO_PT_RELOAD_HI), model_mem[io(IO_PT_RELOAD_HI)]);
    add_read(io(IO_PT_MASK), model_mem[io(IO_PT_MASK)] & 4'h1);
    // Programmable timer reloading 5 and ticking on every clock
    add_write(io(IO_PT_RELOAD_LO), 4'h5);
    add_write(io(IO_PT_RELOAD_HI), 4'h0);
    add_write(io(IO_PT_SEL), 4'h0);
    add_write(io(IO_PT_MASK), 4'h1);
    add_write(io(IO_PT_CTRL), 4'h3);
    add_step(OP_IDLE, '0, '0, '0, 3);
    irq_sel = '0;
    irq_sel.prog_timer = 1'b1;
    add_step(OP_IRQ, '0, 4'(irq_sel), 4'(irq_sel), 0);
    add_read(io(IO_PT_FACTOR), 4'h1);
    add_read(io(IO_PT_FACTOR), 4'h0);
    // K0 with relation 0xF fires only on bit 0 going low
    add_read(io(IO_K0_REL), 4'hF);
    add_write(io(IO_K0_MASK), 4'h1);
    add_step(OP_INPUT, 12'h000, 4'hB, '0, 0);
    add_step(OP_IDLE, '0, '0, '0, 4);
    add_read(io(IO_K0), 4'hB);
    add_read(io(IO_K0_FACTOR), 4'h0);
    add_step(OP_INPUT, 12'h000, 4'hA, '0, 0);
    add_step(OP_IDLE, '0, '0, '0, 4);
    irq_sel = '0;
    irq_sel.input_k0 = 1'b1;
    add_step(OP_IRQ, '0, 4'(irq_sel), 4'(irq_sel), 0);
    add_read(io(IO_K0_FACTOR), 4'h1);
    add_read(io(IO_K0_FACTOR), 4'h0);
    add_read(io(IO_K0), 4'hA);
    // Clock timer restarts from zero at the reset write
    add_write(io(IO_TIMER_RESET), 4'h2);
    since_clear = '0;
    add_step(OP_IDLE, '0, '0, '0, 64);
    add_read(io(IO_CLK_LO), since_clear[3:0]);
    add_read(io(IO_CLK_HI), since_clear[7:4]);
    add_step(OP_IDLE, '0, '0, '0, 256);
    // All clock factors are set here, so any mask bit raises the request
    irq_sel = '0;
    irq_sel.clock = 1'b1;
    add_step(OP_IRQ, '0, 4'(irq_sel),
             (|model_mem[io(IO_CLK_MASK)]) ? 4'(irq_sel) : 4'h0, 0);
    add_read(io(IO_CLK_FACTOR), 4'hF);
  endtask

  task automatic check_value(input string what, input logic [NIB_W-1:0] actual,
                             input logic [NIB_W-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s returned 0x%h, expected 0x%h",
               $time, what, actual, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // Every step starts and ends on a falling edge
  task automatic run_step(input step_t s);
    case (s.op)
      OP_WRITE: begin
        mem_req.write_en = 1'b1;
        mem_req.addr = s.addr;
        mem_req.write_data = s.data;
        @(negedge clk);
        mem_req = '0;
      end
      OP_READ: begin
        mem_req.read_en = 1'b1;
        mem_req.addr = s.addr;
        @(negedge clk);
        mem_req = '0;
        check_value($sformatf("read 0x%03h", s.addr), read_data, s.expected);
      end
      OP_INPUT: begin
        input_k0 = s.data;
        input_k1 = s.addr[3:0];
        @(negedge clk);
      end
      OP_VIDEO: begin
        video_addr = s.addr[7:0];
        @(negedge clk);
        check_value($sformatf("video 0x%02h", s.addr[7:0]), video_data, s.expected);
      end
      OP_IRQ: begin
        check_value("interrupt_req", 4'(interrupt_req) & s.data, s.expected);
      end
      default: begin
        repeat (s.wait_cycles) @(negedge clk);
      end
    endcase
  endtask

  initial begin
    seed = 32'hbf91c36f;
    table_ready = 1'b0;
    since_clear = '0;
    reset_n = 1'b0;
    clk_en = 1'b1;
    mem_req = '0;
    input_k0 = '0;
    input_k1 = '0;
    video_addr = '0;
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    foreach (steps[i]) run_step(steps[i]);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    int cycles;
    wait (table_ready);
    cycles = 3;
    foreach (steps[i]) cycles += int'(steps[i].wait_cycles) + 2;
    // Twice the expected length
    #(cycles * CLK_PERIOD * 2);
    $display("Watchdog timeout: the run did not finish within %0d cycles", cycles * 2);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation timed out");
  end

endmodule

/* verilog/clock_timer.sv */
`timescale 1ns/1ps

module clock_timer (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       clear,
  output logic [7:0] taps,
  output logic [3:0] clock_pulses
);

  logic [7:0] taps_prev;
  logic [7:0] taps_fall;

  // Bit 0 is 128 Hz, bit 7 is 1 Hz
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      taps <= '0;
      taps_prev <= '0;
    end else if (clk_en) begin
      if (clear) begin
        taps <= '0;
        // Keep the clear from looking like a falling edge
        taps_prev <= '0;
      end else begin
        taps <= taps + 8'd1;
        taps_prev <= taps;
      end
    end
  end

  assign taps_fall = taps_prev & ~taps;

  // 32 Hz, 8 Hz, 2 Hz and 1 Hz falling edges
  assign clock_pulses = {taps_fall[7], taps_fall[6], taps_fall[4], taps_fall[2]}
                        & {4{clk_en}};

endmodule

/* verilog/input_port.sv */
`timescale 1ns/1ps

module input_port (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic [3:0] k0,
  input  logic [3:0] k1,
  input  logic [3:0] relation,
  input  logic [3:0] k0_mask,
  input  logic [3:0] k1_mask,
  output logic [3:0] k0_sync,
  output logic [3:0] k1_sync,
  output logic [1:0] k_set
);

  logic [3:0] k0_meta;
  logic [3:0] k1_meta;
  logic [3:0] k0_prev;
  logic [3:0] k1_prev;
  logic [3:0] k0_hit;
  logic [3:0] k1_hit;

  // Two-flop synchronizer runs on every clk
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      k0_meta <= '0;
      k1_meta <= '0;
      k0_sync <= '0;
      k1_sync <= '0;
    end else begin
      k0_meta <= k0;
      k1_meta <= k1;
      k0_sync <= k0_meta;
      k1_sync <= k1_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      k0_prev <= '0;
      k1_prev <= '0;
    end else if (clk_en) begin
      k0_prev <= k0_sync;
      k1_prev <= k1_sync;
    end
  end

  // K0 fires on a change away from the relation level
  assign k0_hit = (k0_prev ^ k0_sync) & (k0_sync ^ relation) & k0_mask;
  // K1 fires on falling edges only
  assign k1_hit = k1_prev & ~k1_sync & k1_mask;

  assign k_set = {|k1_hit, |k0_hit} & {2{clk_en}};

endmodule

/* verilog/interrupt_ctrl.sv */
`timescale 1ns/1ps

module interrupt_ctrl (
  input  logic          clk,
  input  logic          reset_n,
  input  logic          clk_en,
  input  logic [3:0]    clock_pulses,
  input  logic          pt_underflow,
  input  logic [1:0]    k_set,
  input  s46_pkg::irq_t factor_clear,
  input  logic [3:0]    clock_mask,
  input  logic          pt_mask,
  input  logic          k0_mask_any,
  input  logic          k1_mask_any,
  output logic [3:0]    clock_factor,
  output logic          pt_factor,
  output logic [1:0]    k_factor,
  output s46_pkg::irq_t interrupt_req
);

  // Clear first, then set, so a new event on the read edge is kept
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      clock_factor <= '0;
      pt_factor <= 1'b0;
      k_factor <= '0;
    end else if (clk_en) begin
      clock_factor <= (clock_factor & ~{4{factor_clear.clock}}) | clock_pulses;
      pt_factor <= (pt_factor & ~factor_clear.prog_timer) | pt_underflow;
      k_factor[0] <= (k_factor[0] & ~factor_clear.input_k0) | k_set[0];
      k_factor[1] <= (k_factor[1] & ~factor_clear.input_k1) | k_set[1];
    end
  end

  // Requests follow the flags without a register stage
  assign interrupt_req.clock = |(clock_factor & clock_mask);
  assign interrupt_req.prog_timer = pt_factor & pt_mask;
  assign interrupt_req.input_k0 = k_factor[0] & k0_mask_any;
  assign interrupt_req.input_k1 = k_factor[1] & k1_mask_any;

endmodule

/* verilog/mem_map.sv */
`timescale 1ns/1ps

module mem_map (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      clk_en,
  input  s46_pkg::mem_req_t         mem_req,
  output logic [s46_pkg::NIB_W-1:0] read_data,
  output logic                      ram_we,
  output logic                      vram_we,
  output logic [7:0]                vram_addr,
  input  logic [s46_pkg::NIB_W-1:0] ram_rdata,
  input  logic [s46_pkg::NIB_W-1:0] vram_rdata,
  input  logic [3:0]                clock_factor,
  input  logic                      pt_factor,
  input  logic [1:0]                k_factor,
  input  logic [7:0]                taps,
  input  logic [7:0]                count,
  input  logic [3:0]                k0_sync,
  input  logic [3:0]                k1_sync,
  output s46_pkg::pt_ctrl_t         pt_ctrl,
  output logic                      clock_reset,
  output logic [3:0]                clock_mask,
  output logic                      pt_mask,
  output logic [3:0]                k0_mask,
  output logic [3:0]                k1_mask,
  output logic [3:0]                relation,
  output s46_pkg::irq_t             factor_clear
);
  import s46_pkg::*;

  logic             wr;
  logic             rd;
  logic             in_ram;
  logic             in_vram_lo;
  logic             in_vram_hi;
  logic             in_io;
  logic [7:0]       io_offset;
  logic [NIB_W-1:0] io_rdata;
  logic [NIB_W-1:0] rdata_mux;
  logic             pt_enable;
  logic             pt_load;
  logic [2:0]       pt_sel;
  logic [7:0]       pt_reload;

  assign wr = clk_en & mem_req.write_en;
  assign rd = clk_en & mem_req.read_en;
  assign io_offset = mem_req.addr[7:0];

  // Region decode
  assign in_ram = mem_req.addr < MAIN_RAM_END;
  assign in_vram_lo = (mem_req.addr >= VRAM_LO_BASE) &&
                      (mem_req.addr < VRAM_LO_BASE + VRAM_WIN);
  assign in_vram_hi = (mem_req.addr >= VRAM_HI_BASE) &&
                      (mem_req.addr < VRAM_HI_BASE + VRAM_WIN);
  assign in_io = mem_req.addr[ADDR_W-1:8] == IO_PAGE;

  // Upper window continues right after the lower one
  always_comb begin
    if (in_vram_hi) begin
      vram_addr = 8'(mem_req.addr - VRAM_HI_BASE + VRAM_WIN);
    end else if (in_vram_lo) begin
      vram_addr = 8'(mem_req.addr - VRAM_LO_BASE);
    end else begin
      vram_addr = '0;
    end
  end

  assign ram_we = wr & in_ram;
  assign vram_we = wr & (in_vram_lo | in_vram_hi);

  assign clock_reset = wr & in_io & (io_offset == IO_TIMER_RESET) & mem_req.write_data[1];

  // Factor reads clear on the same edge that samples them
  assign factor_clear.clock = rd & in_io & (io_offset == IO_CLK_FACTOR);
  assign factor_clear.prog_timer = rd & in_io & (io_offset == IO_PT_FACTOR);
  assign factor_clear.input_k0 = rd & in_io & (io_offset == IO_K0_FACTOR);
  assign factor_clear.input_k1 = rd & in_io & (io_offset == IO_K1_FACTOR);

  always_comb begin
    case (io_offset)
      IO_CLK_FACTOR:   io_rdata = clock_factor;
      IO_PT_FACTOR:    io_rdata = {3'b0, pt_factor};
      IO_K0_FACTOR:    io_rdata = {3'b0, k_factor[0]};
      IO_K1_FACTOR:    io_rdata = {3'b0, k_factor[1]};
      IO_CLK_MASK:     io_rdata = clock_mask;
      IO_PT_MASK:      io_rdata = {3'b0, pt_mask};
      IO_K0_MASK:      io_rdata = k0_mask;
      IO_K1_MASK:      io_rdata = k1_mask;
      IO_CLK_LO:       io_rdata = taps[3:0];
      IO_CLK_HI:       io_rdata = taps[7:4];
      IO_PT_LO:        io_rdata = count[3:0];
      IO_PT_HI:        io_rdata = count[7:4];
      IO_PT_RELOAD_LO: io_rdata = pt_reload[3:0];
      IO_PT_RELOAD_HI: io_rdata = pt_reload[7:4];
      IO_K0:           io_rdata = k0_sync;
      IO_K0_REL:       io_rdata = relation;
      IO_K1:           io_rdata = k1_sync;
      IO_PT_CTRL:      io_rdata = {3'b0, pt_enable};
      IO_PT_SEL:       io_rdata = {1'b0, pt_sel};
      default:         io_rdata = '0;
    endcase
  end

  always_comb begin
    if (in_ram) begin
      rdata_mux = ram_rdata;
    end else if (in_vram_lo || in_vram_hi) begin
      rdata_mux = vram_rdata;
    end else if (in_io) begin
      rdata_mux = io_rdata;
    end else begin
      rdata_mux = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_data <= '0;
      clock_mask <= '0;
      pt_mask <= 1'b0;
      k0_mask <= '0;
      k1_mask <= '0;
      relation <= 4'hF;
      pt_enable <= 1'b0;
      pt_load <= 1'b0;
      pt_sel <= '0;
      pt_reload <= '0;
    end else if (clk_en) begin
      // Load is a single-step pulse
      pt_load <= 1'b0;
      if (mem_req.read_en) begin
        read_data <= rdata_mux;
      end
      if (mem_req.write_en && in_io) begin
        case (io_offset)
          IO_CLK_MASK:     clock_mask <= mem_req.write_data;
          IO_PT_MASK:      pt_mask <= mem_req.write_data[0];
          IO_K0_MASK:      k0_mask <= mem_req.write_data;
          IO_K1_MASK:      k1_mask <= mem_req.write_data;
          IO_PT_RELOAD_LO: pt_reload[3:0] <= mem_req.write_data;
          IO_PT_RELOAD_HI: pt_reload[7:4] <= mem_req.write_data;
          IO_K0_REL:       relation <= mem_req.write_data;
          IO_PT_CTRL: begin
            pt_load <= mem_req.write_data[1];
            pt_enable <= mem_req.write_data[0];
          end
          IO_PT_SEL:       pt_sel <= mem_req.write_data[2:0];
          default: ;
        endcase
      end
    end
  end

  assign pt_ctrl.enable = pt_enable;
  assign pt_ctrl.load = pt_load;
  assign pt_ctrl.sel = pt_sel;
  assign pt_ctrl.reload = pt_reload;

endmodule

/* verilog/nibble_ram.sv */
`timescale 1ns/1ps

module nibble_ram #(
  parameter int DEPTH = 640,
  parameter int ADDR_BITS = 10
) (
  input  logic                      clk,
  input  logic                      we,
  input  logic [ADDR_BITS-1:0]      waddr,
  input  logic [s46_pkg::NIB_W-1:0] wdata,
  input  logic [ADDR_BITS-1:0]      raddr_a,
  output logic [s46_pkg::NIB_W-1:0] rdata_a,
  input  logic [ADDR_BITS-1:0]      raddr_b,
  output logic [s46_pkg::NIB_W-1:0] rdata_b
);
  import s46_pkg::*;

  logic [NIB_W-1:0] mem [DEPTH];
  logic [ADDR_BITS-1:0] index_a;
  logic [ADDR_BITS-1:0] index_b;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Out-of-range reads fold back to entry 0
  assign index_a = (raddr_a < DEPTH) ? raddr_a : '0;
  assign index_b = (raddr_b < DEPTH) ? raddr_b : '0;

  assign rdata_a = mem[index_a];
  assign rdata_b = mem[index_b];

endmodule

/* verilog/prog_timer.sv */
`timescale 1ns/1ps

module prog_timer (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              clk_en,
  input  s46_pkg::pt_ctrl_t ctrl,
  input  logic [7:0]        taps,
  output logic [7:0]        count,
  output logic              underflow
);

  logic [7:0] taps_prev;
  logic [7:0] taps_fall;
  logic [2:0] tap_index;
  logic       tick;

  assign taps_fall = taps_prev & ~taps;

  // Sel 1 picks 128 Hz, sel 7 picks 2 Hz
  assign tap_index = ctrl.sel - 3'd1;

  // Sel 0 counts every enabled clock
  assign tick = (ctrl.sel == 3'd0) ? 1'b1 : taps_fall[tap_index];

  assign underflow = clk_en & ctrl.enable & tick & (count == 8'd0);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      taps_prev <= '0;
      count <= '0;
    end else if (clk_en) begin
      taps_prev <= taps;
      if (ctrl.load || underflow) begin
        // Both an explicit load and a wrap take the reload value
        count <= ctrl.reload;
      end else if (ctrl.enable && tick) begin
        count <= count - 8'd1;
      end
    end
  end

endmodule

/* verilog/s46_peripherals.sv */
`timescale 1ns/1ps

module s46_peripherals #(
  parameter int RAM_DEPTH = 640,
  parameter int RAM_ADDR_BITS = 10,
  parameter int VRAM_DEPTH = 160,
  parameter int VRAM_ADDR_BITS = 8
) (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      clk_en,
  input  s46_pkg::mem_req_t         mem_req,
  output logic [s46_pkg::NIB_W-1:0] read_data,
  input  logic [3:0]                input_k0,
  input  logic [3:0]                input_k1,
  input  logic [VRAM_ADDR_BITS-1:0] video_addr,
  output logic [s46_pkg::NIB_W-1:0] video_data,
  output s46_pkg::irq_t             interrupt_req
);
  import s46_pkg::*;

  logic                      ram_we;
  logic                      vram_we;
  logic [VRAM_ADDR_BITS-1:0] vram_addr;
  logic [NIB_W-1:0]          ram_rdata;
  logic [NIB_W-1:0]          vram_rdata;
  pt_ctrl_t                  pt_ctrl;
  logic                      clock_reset;
  logic [3:0]                clock_mask;
  logic                      pt_mask;
  logic [3:0]                k0_mask;
  logic [3:0]                k1_mask;
  logic [3:0]                relation;
  irq_t                      factor_clear;
  logic [7:0]                taps;
  logic [3:0]                clock_pulses;
  logic [7:0]                count;
  logic                      pt_underflow;
  logic [3:0]                k0_sync;
  logic [3:0]                k1_sync;
  logic [1:0]                k_set;
  logic [3:0]                clock_factor;
  logic                      pt_factor;
  logic [1:0]                k_factor;

  mem_map u_mem_map (
    .clk          (clk),
    .reset_n      (reset_n),
    .clk_en       (clk_en),
    .mem_req      (mem_req),
    .read_data    (read_data),
    .ram_we       (ram_we),
    .vram_we      (vram_we),
    .vram_addr    (vram_addr),
    .ram_rdata    (ram_rdata),
    .vram_rdata   (vram_rdata),
    .clock_factor (clock_factor),
    .pt_factor    (pt_factor),
    .k_factor     (k_factor),
    .taps         (taps),
    .count        (count),
    .k0_sync      (k0_sync),
    .k1_sync      (k1_sync),
    .pt_ctrl      (pt_ctrl),
    .clock_reset  (clock_reset),
    .clock_mask   (clock_mask),
    .pt_mask      (pt_mask),
    .k0_mask      (k0_mask),
    .k1_mask      (k1_mask),
    .relation     (relation),
    .factor_clear (factor_clear)
  );

  // Main RAM, second port not needed
  nibble_ram #(
    .DEPTH     (RAM_DEPTH),
    .ADDR_BITS (RAM_ADDR_BITS)
  ) u_main_ram (
    .clk     (clk),
    .we      (ram_we),
    .waddr   (mem_req.addr[RAM_ADDR_BITS-1:0]),
    .wdata   (mem_req.write_data),
    .raddr_a (mem_req.addr[RAM_ADDR_BITS-1:0]),
    .rdata_a (ram_rdata),
    .raddr_b ('0),
    .rdata_b ()
  );

  // Display RAM, port b feeds the video scanner
  nibble_ram #(
    .DEPTH     (VRAM_DEPTH),
    .ADDR_BITS (VRAM_ADDR_BITS)
  ) u_video_ram (
    .clk     (clk),
    .we      (vram_we),
    .waddr   (vram_addr),
    .wdata   (mem_req.write_data),
    .raddr_a (vram_addr),
    .rdata_a (vram_rdata),
    .raddr_b (video_addr),
    .rdata_b (video_data)
  );

  clock_timer u_clock_timer (
    .clk          (clk),
    .reset_n      (reset_n),
    .clk_en       (clk_en),
    .clear        (clock_reset),
    .taps         (taps),
    .clock_pulses (clock_pulses)
  );

  prog_timer u_prog_timer (
    .clk       (clk),
    .reset_n   (reset_n),
    .clk_en    (clk_en),
    .ctrl      (pt_ctrl),
    .taps      (taps),
    .count     (count),
    .underflow (pt_underflow)
  );

  input_port u_input_port (
    .clk      (clk),
    .reset_n  (reset_n),
    .clk_en   (clk_en),
    .k0       (input_k0),
    .k1       (input_k1),
    .relation (relation),
    .k0_mask  (k0_mask),
    .k1_mask  (k1_mask),
    .k0_sync  (k0_sync),
    .k1_sync  (k1_sync),
    .k_set    (k_set)
  );

  interrupt_ctrl u_interrupt_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .clk_en        (clk_en),
    .clock_pulses  (clock_pulses),
    .pt_underflow  (pt_underflow),
    .k_set         (k_set),
    .factor_clear  (factor_clear),
    .clock_mask    (clock_mask),
    .pt_mask       (pt_mask),
    .k0_mask_any   (|k0_mask),
    .k1_mask_any   (|k1_mask),
    .clock_factor  (clock_factor),
    .pt_factor     (pt_factor),
    .k_factor      (k_factor),
    .interrupt_req (interrupt_req)
  );

endmodule

/* verilog/s46_pkg.sv */
package s46_pkg;

  localparam int ADDR_W = 12;
  localparam int NIB_W = 4;

  // Data memory map
  localparam logic [ADDR_W-1:0] MAIN_RAM_END = 12'h280;
  localparam logic [ADDR_W-1:0] VRAM_LO_BASE = 12'hE00;
  localparam logic [ADDR_W-1:0] VRAM_HI_BASE = 12'hE80;
  localparam logic [ADDR_W-1:0] VRAM_WIN = 12'h050;
  localparam logic [ADDR_W-1:0] VRAM_DEPTH = 12'h0A0;
  localparam logic [3:0] IO_PAGE = 4'hF;

  // Offsets inside the I/O page
  localparam logic [7:0] IO_CLK_FACTOR = 8'h00;
  localparam logic [7:0] IO_PT_FACTOR = 8'h02;
  localparam logic [7:0] IO_K0_FACTOR = 8'h04;
  localparam logic [7:0] IO_K1_FACTOR = 8'h05;
  localparam logic [7:0] IO_CLK_MASK = 8'h10;
  localparam logic [7:0] IO_PT_MASK = 8'h12;
  localparam logic [7:0] IO_K0_MASK = 8'h14;
  localparam logic [7:0] IO_K1_MASK = 8'h15;
  localparam logic [7:0] IO_CLK_LO = 8'h20;
  localparam logic [7:0] IO_CLK_HI = 8'h21;
  localparam logic [7:0] IO_PT_LO = 8'h24;
  localparam logic [7:0] IO_PT_HI = 8'h25;
  localparam logic [7:0] IO_PT_RELOAD_LO = 8'h26;
  localparam logic [7:0] IO_PT_RELOAD_HI = 8'h27;
  localparam logic [7:0] IO_K0 = 8'h40;
  localparam logic [7:0] IO_K0_REL = 8'h41;
  localparam logic [7:0] IO_K1 = 8'h42;
  localparam logic [7:0] IO_TIMER_RESET = 8'h76;
  localparam logic [7:0] IO_PT_CTRL = 8'h78;
  localparam logic [7:0] IO_PT_SEL = 8'h79;

  // CPU data-memory request
  typedef struct packed {
    logic              write_en;
    logic              read_en;
    logic [ADDR_W-1:0] addr;
    logic [NIB_W-1:0]  write_data;
  } mem_req_t;

  typedef struct packed {
    logic       enable;
    logic       load;
    logic [2:0] sel;
    logic [7:0] reload;
  } pt_ctrl_t;

  // One bit per interrupt source
  typedef struct packed {
    logic clock;
    logic prog_timer;
    logic input_k0;
    logic input_k1;
  } irq_t;

endpackage
